//--- dmac.f
+incdir+src
src/dmac_pkg.sv
src/dmac_reg_frontend.sv
src/dmac_req_fifo.sv
src/dmac_2d_midend.sv
src/dmac_copy_backend.sv
src/dmac_top.sv
verification/dmac_props.sv
verification/dmac_tb.sv

//--- src/dmac_2d_midend.sv
// --------------------
// 2D midend, splits a job into REPS row bursts and counts their completion
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_2d_midend (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  dmac_pkg::nd_req_t    nd_req_i,
  input  logic                 nd_valid_i,
  output logic                 nd_ready_o,
  output dmac_pkg::burst_req_t burst_o,
  output logic                 burst_valid_o,
  input  logic                 burst_ready_i,
  input  logic                 burst_done_i,
  output logic                 xfer_done_o,
  output logic                 busy_o
);

  dmac_pkg::nd_req_t       job_q;
  logic                    active_q;
  logic [`DMAC_ADDR_W-1:0] src_q, dst_q;
  logic [`DMAC_REPS_W-1:0] issue_cnt_q, done_cnt_q, done_cnt_nxt;
  logic                    nd_accept, burst_accept;

  assign nd_ready_o    = ~active_q;
  assign nd_accept     = nd_valid_i & nd_ready_o;
  assign burst_valid_o = active_q & (issue_cnt_q != job_q.reps);
  assign burst_accept  = burst_valid_o & burst_ready_i;
  assign burst_o       = '{src: src_q, dst: dst_q, len: job_q.len};
  assign done_cnt_nxt  = done_cnt_q + 1'b1;
  // Last row done frees the job in the same cycle
  assign xfer_done_o   = active_q & burst_done_i & (done_cnt_nxt == job_q.reps);
  assign busy_o        = active_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q    <= 1'b0;
      issue_cnt_q <= '0;
      done_cnt_q  <= '0;
    end else begin
      if (nd_accept) begin
        active_q    <= 1'b1;
        issue_cnt_q <= '0;
        done_cnt_q  <= '0;
      end else begin
        if (burst_accept) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
        end
        if (xfer_done_o) begin
          active_q <= 1'b0;
        end else if (burst_done_i) begin
          done_cnt_q <= done_cnt_nxt;
        end
      end
    end
  end

  // Job and running row addresses
  always_ff @(posedge clk_i) begin
    if (nd_accept) begin
      job_q <= nd_req_i;
      src_q <= nd_req_i.src;
      dst_q <= nd_req_i.dst;
    end else if (burst_accept) begin
      src_q <= src_q + job_q.src_stride;
      dst_q <= dst_q + job_q.dst_stride;
    end
  end

endmodule

//--- src/dmac_copy_backend.sv
// --------------------
// Copy backend, moves one burst word by word over the memory port
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_copy_backend (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  dmac_pkg::burst_req_t    burst_i,
  input  logic                    burst_valid_i,
  output logic                    burst_ready_o,
  output logic                    burst_done_o,
  output logic                    busy_o,
  output logic                    mem_req_o,
  output logic [`DMAC_ADDR_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`DMAC_DATA_W-1:0] mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [`DMAC_DATA_W-1:0] mem_rdata_i
);

  localparam logic [`DMAC_ADDR_W-1:0] WORD_BYTES = `DMAC_ADDR_W'(`DMAC_DATA_W / 8);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_WRITE
  } state_e;

  state_e                  state_q;
  logic [`DMAC_ADDR_W-1:0] src_q, dst_q, rem_q;
  logic [`DMAC_DATA_W-1:0] data_q;
  logic                    burst_accept, write_gnt, last_word;

  assign burst_ready_o = (state_q == ST_IDLE);
  assign burst_accept  = burst_valid_i & burst_ready_o;
  assign busy_o        = (state_q != ST_IDLE);

  // Request and address held steady until granted
  assign mem_req_o   = (state_q == ST_READ) | (state_q == ST_WRITE);
  assign mem_we_o    = (state_q == ST_WRITE);
  assign mem_addr_o  = (state_q == ST_WRITE) ? dst_q : src_q;
  assign mem_wdata_o = data_q;

  assign write_gnt    = (state_q == ST_WRITE) & mem_gnt_i;
  assign last_word    = (rem_q == WORD_BYTES);
  assign burst_done_o = write_gnt & last_word;

  // --------------------
  // Word FSM
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (burst_accept) state_q <= ST_READ;
        ST_READ:  if (mem_gnt_i) state_q <= ST_WAIT;
        ST_WAIT:  if (mem_rvalid_i) state_q <= ST_WRITE;
        ST_WRITE: begin
          if (mem_gnt_i) begin
            state_q <= last_word ? ST_IDLE : ST_READ;
          end
        end
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // Addresses, remaining bytes and the word in flight
  always_ff @(posedge clk_i) begin
    if (burst_accept) begin
      src_q <= burst_i.src;
      dst_q <= burst_i.dst;
      rem_q <= burst_i.len;
    end else if (write_gnt) begin
      src_q <= src_q + WORD_BYTES;
      dst_q <= dst_q + WORD_BYTES;
      rem_q <= rem_q - WORD_BYTES;
    end
    if (state_q == ST_WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule

//--- src/dmac_defs.svh
// --------------------
// DMA controller shared widths, queue depths and register offsets
// --------------------
`ifndef DMAC_DEFS_SVH
`define DMAC_DEFS_SVH

// Datapath widths
`define DMAC_ADDR_W 32
`define DMAC_DATA_W 32
`define DMAC_REPS_W 16
`define DMAC_ID_W   28

// Queue depths
`define DMAC_QUEUE_DEPTH 4
`define DMAC_BURST_DEPTH 2

// Register map, byte offsets
`define DMAC_REG_OFF_W      8
`define DMAC_REG_SRC        8'h00
`define DMAC_REG_DST        8'h04
`define DMAC_REG_LEN        8'h08
`define DMAC_REG_SRC_STRIDE 8'h0C
`define DMAC_REG_DST_STRIDE 8'h10
`define DMAC_REG_REPS       8'h14
`define DMAC_REG_NEXT_ID    8'h18
`define DMAC_REG_DONE_ID    8'h1C

`endif

//--- src/dmac_pkg.sv
// --------------------
// DMA controller request types
// --------------------
`include "dmac_defs.svh"

package dmac_pkg;

  // 2D job as launched through the register frontend
  typedef struct packed {
    logic [`DMAC_ADDR_W-1:0] src;
    logic [`DMAC_ADDR_W-1:0] dst;
    logic [`DMAC_ADDR_W-1:0] len;
    logic [`DMAC_ADDR_W-1:0] src_stride;
    logic [`DMAC_ADDR_W-1:0] dst_stride;
    logic [`DMAC_REPS_W-1:0] reps;
  } nd_req_t;

  // One row of a 2D job
  typedef struct packed {
    logic [`DMAC_ADDR_W-1:0] src;
    logic [`DMAC_ADDR_W-1:0] dst;
    logic [`DMAC_ADDR_W-1:0] len;
  } burst_req_t;

endpackage

//--- src/dmac_reg_frontend.sv
// --------------------
// AXI4-Lite register file of the DMA controller
// A read of NEXT_ID launches the configured transfer and returns its ID
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_reg_frontend (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`DMAC_ADDR_W-1:0] awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [`DMAC_DATA_W-1:0] wdata_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output logic [1:0]              bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  logic [`DMAC_ADDR_W-1:0] araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output logic [`DMAC_DATA_W-1:0] rdata_o,
  output logic [1:0]              rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output dmac_pkg::nd_req_t       req_o,
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  input  logic                    xfer_done_i
);

  localparam logic [1:0]  RESP_OKAY = 2'b00;
  localparam int unsigned ID_PAD    = `DMAC_DATA_W - `DMAC_ID_W;
  localparam int unsigned REPS_PAD  = `DMAC_DATA_W - `DMAC_REPS_W;

  logic [`DMAC_ADDR_W-1:0]    src_q, dst_q, len_q, src_stride_q, dst_stride_q;
  logic [`DMAC_REPS_W-1:0]    reps_q;
  logic [`DMAC_ID_W-1:0]      next_id_q, done_id_q, launch_id;
  logic                       bvalid_q, rvalid_q, launch_q;
  logic [`DMAC_DATA_W-1:0]    rdata_q, reg_rdata;
  logic                       wr_accept, rd_accept, launch_accept;
  logic [`DMAC_REG_OFF_W-1:0] wr_off, rd_off;

  assign wr_off        = awaddr_i[`DMAC_REG_OFF_W-1:0];
  assign rd_off        = araddr_i[`DMAC_REG_OFF_W-1:0];
  assign wr_accept     = awvalid_i & wvalid_i & ~bvalid_q;
  // No new read while a response or a launch is pending
  assign rd_accept     = arvalid_i & ~rvalid_q & ~launch_q;
  assign launch_accept = launch_q & req_ready_i;
  // IDs start at 1, so ID n is complete once DONE_ID reaches n
  assign launch_id     = next_id_q + 1'b1;

  assign awready_o   = wr_accept;
  assign wready_o    = wr_accept;
  assign bvalid_o    = bvalid_q;
  assign bresp_o     = RESP_OKAY;
  assign arready_o   = rd_accept;
  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign rresp_o     = RESP_OKAY;
  assign req_valid_o = launch_q;
  assign req_o       = '{src: src_q, dst: dst_q, len: len_q, src_stride: src_stride_q,
                         dst_stride: dst_stride_q, reps: reps_q};

  // --------------------
  // Write channel
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q     <= 1'b0;
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else begin
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (wr_accept) begin
        bvalid_q <= 1'b1;
        case (wr_off)
          `DMAC_REG_SRC:        src_q        <= wdata_i;
          `DMAC_REG_DST:        dst_q        <= wdata_i;
          `DMAC_REG_LEN:        len_q        <= wdata_i;
          `DMAC_REG_SRC_STRIDE: src_stride_q <= wdata_i;
          `DMAC_REG_DST_STRIDE: dst_stride_q <= wdata_i;
          `DMAC_REG_REPS:       reps_q       <= wdata_i[`DMAC_REPS_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // Read channel
  // --------------------
  always_comb begin
    case (rd_off)
      `DMAC_REG_SRC:        reg_rdata = src_q;
      `DMAC_REG_DST:        reg_rdata = dst_q;
      `DMAC_REG_LEN:        reg_rdata = len_q;
      `DMAC_REG_SRC_STRIDE: reg_rdata = src_stride_q;
      `DMAC_REG_DST_STRIDE: reg_rdata = dst_stride_q;
      `DMAC_REG_REPS:       reg_rdata = {{REPS_PAD{1'b0}}, reps_q};
      `DMAC_REG_DONE_ID:    reg_rdata = {{ID_PAD{1'b0}}, done_id_q};
      default:              reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q  <= 1'b0;
      launch_q  <= 1'b0;
      next_id_q <= '0;
    end else begin
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        // NEXT_ID answers only once the queue has taken the job
        if (rd_off == `DMAC_REG_NEXT_ID) begin
          launch_q <= 1'b1;
        end else begin
          rvalid_q <= 1'b1;
        end
      end
      if (launch_accept) begin
        launch_q  <= 1'b0;
        rvalid_q  <= 1'b1;
        next_id_q <= launch_id;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch_accept) begin
      rdata_q <= {{ID_PAD{1'b0}}, launch_id};
    end else if (rd_accept) begin
      rdata_q <= reg_rdata;
    end
  end

  // Completed transfers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_id_q <= '0;
    end else if (xfer_done_i) begin
      done_id_q <= done_id_q + 1'b1;
    end
  end

endmodule

//--- src/dmac_req_fifo.sv
// --------------------
// Valid/ready request FIFO for any payload type
// --------------------
`timescale 1ns/10ps

module dmac_req_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push, pop;

  assign ready_o = (count_q != (PTR_W+1)'(DEPTH));
  assign valid_o = (count_q != '0);
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- src/dmac_top.sv
// --------------------
// 2D DMA controller top, frontend to queue to midend to backend
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // AXI4-Lite register port
  input  logic [`DMAC_ADDR_W-1:0] awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [`DMAC_DATA_W-1:0] wdata_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output logic [1:0]              bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  logic [`DMAC_ADDR_W-1:0] araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output logic [`DMAC_DATA_W-1:0] rdata_o,
  output logic [1:0]              rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  // Memory port
  output logic                    mem_req_o,
  output logic [`DMAC_ADDR_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`DMAC_DATA_W-1:0] mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [`DMAC_DATA_W-1:0] mem_rdata_i,
  // Status
  output logic                    term_event_o,
  output logic                    busy_o
);

  dmac_pkg::nd_req_t    fe_req, nd_req;
  dmac_pkg::burst_req_t mid_burst, be_burst;
  logic fe_valid, fe_ready, nd_valid, nd_ready, nd_empty;
  logic mid_valid, mid_ready, be_valid, be_ready, burst_empty;
  logic burst_done, xfer_done, midend_busy, backend_busy;

  assign term_event_o = xfer_done;
  assign busy_o       = ~nd_empty | ~burst_empty | midend_busy | backend_busy;

  // --------------------
  // Frontend and global queue
  // --------------------
  dmac_reg_frontend u_frontend (
    .clk_i, .rst_n_i,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .req_o       (fe_req),
    .req_valid_o (fe_valid),
    .req_ready_i (fe_ready),
    .xfer_done_i (xfer_done)
  );

  dmac_req_fifo #(.T(dmac_pkg::nd_req_t), .DEPTH(`DMAC_QUEUE_DEPTH)) u_nd_queue (
    .clk_i, .rst_n_i,
    .data_i (fe_req), .valid_i (fe_valid), .ready_o (fe_ready),
    .data_o (nd_req), .valid_o (nd_valid), .ready_i (nd_ready),
    .empty_o (nd_empty)
  );

  // --------------------
  // Midend and backend
  // --------------------
  dmac_2d_midend u_midend (
    .clk_i, .rst_n_i,
    .nd_req_i (nd_req), .nd_valid_i (nd_valid), .nd_ready_o (nd_ready),
    .burst_o (mid_burst), .burst_valid_o (mid_valid), .burst_ready_i (mid_ready),
    .burst_done_i (burst_done),
    .xfer_done_o  (xfer_done),
    .busy_o       (midend_busy)
  );

  dmac_req_fifo #(.T(dmac_pkg::burst_req_t), .DEPTH(`DMAC_BURST_DEPTH)) u_burst_queue (
    .clk_i, .rst_n_i,
    .data_i (mid_burst), .valid_i (mid_valid), .ready_o (mid_ready),
    .data_o (be_burst), .valid_o (be_valid), .ready_i (be_ready),
    .empty_o (burst_empty)
  );

  dmac_copy_backend u_backend (
    .clk_i, .rst_n_i,
    .burst_i (be_burst), .burst_valid_i (be_valid), .burst_ready_o (be_ready),
    .burst_done_o (burst_done),
    .busy_o       (backend_busy),
    .mem_req_o, .mem_addr_o, .mem_we_o, .mem_wdata_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
  );

endmodule

//--- verification/dmac_props.sv
// --------------------
// DMA controller protocol assertions, bound to the top level
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_props (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    mem_req_i,
  input logic                    mem_gnt_i,
  input logic [`DMAC_ADDR_W-1:0] mem_addr_i,
  input logic                    term_event_i,
  input logic                    busy_i,
  input logic                    req_valid_i,
  input logic                    req_ready_i,
  input logic [`DMAC_ADDR_W-1:0] req_len_i,
  input logic [`DMAC_REPS_W-1:0] req_reps_i
);

  // Memory request held until granted
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i))
    else $error("Memory request or address changed before its grant");

  a_event_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    term_event_i |=> !term_event_i)
    else $error("term_event_o stayed high for more than one cycle");

  // Busy drops only in the cycle after a transfer completes
  a_event_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(busy_i) |-> $past(term_event_i))
    else $error("busy_o fell without a preceding term_event_o");

  // Zero length or zero repetitions are unsupported
  a_launch_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_i |-> (req_len_i != '0) && (req_reps_i != '0))
    else $error("Transfer launched with zero length or zero repetitions");

endmodule

bind dmac_top dmac_props u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .mem_req_i    (mem_req_o),
  .mem_gnt_i    (mem_gnt_i),
  .mem_addr_i   (mem_addr_o),
  .term_event_i (term_event_o),
  .busy_i       (busy_o),
  .req_valid_i  (fe_valid),
  .req_ready_i  (fe_ready),
  .req_len_i    (fe_req.len),
  .req_reps_i   (fe_req.reps)
);

//--- verification/dmac_tb.sv
// --------------------
// Testbench for the 2D DMA controller with a memory model
// --------------------
`timescale 1ns/10ps
`include "dmac_defs.svh"

module dmac_tb;

  localparam int unsigned MEM_WORDS    = 1024;
  localparam int unsigned HS_TIMEOUT   = 2000;
  localparam int unsigned XFER_TIMEOUT = 20000;

  logic        clk, rst_n;
  logic [31:0] awaddr, wdata, araddr, rdata, mem_addr, mem_wdata, mem_rdata;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  logic        mem_req, mem_we, mem_gnt, mem_rvalid, term_event, busy;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] cfg_src, cfg_dst, cfg_len, cfg_src_stride, cfg_dst_stride, cfg_reps;
  int unsigned errors, checks, events, launched, stall_cnt, rd_wait, rd_idx;
  bit          stall_en;

  dmac_top u_dmac_top (
    .clk_i (clk), .rst_n_i (rst_n),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_we_o (mem_we),
    .mem_wdata_o (mem_wdata), .mem_gnt_i (mem_gnt), .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i (mem_rdata),
    .term_event_o (term_event), .busy_o (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0100_0193) ^ 32'hc3a5_0f1e;
  endfunction

  // --------------------
  // Memory model
  // --------------------
  always @(posedge clk) begin
    mem_gnt    <= 1'b0;
    mem_rvalid <= 1'b0;
    if (rd_wait != 0) begin
      rd_wait = rd_wait - 1;
      if (rd_wait == 0) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= mem[rd_idx];
      end
    end else if (mem_req && !mem_gnt) begin
      if (stall_cnt != 0) begin
        stall_cnt = stall_cnt - 1;
      end else begin
        mem_gnt <= 1'b1;
        if (mem_we) begin
          mem[(mem_addr >> 2) % MEM_WORDS] = mem_wdata;
        end else begin
          rd_idx  = (mem_addr >> 2) % MEM_WORDS;
          rd_wait = $urandom % 3 + 1;
        end
        stall_cnt = stall_en ? $urandom % 4 : 0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && term_event) begin
      events <= events + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // --------------------
  // AXI4-Lite accesses
  // --------------------
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    int unsigned t;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!awready && t < HS_TIMEOUT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!awready) begin
      $display("Timeout: write to %h was never accepted", addr);
      errors++;
    end else begin
      // Address and data are taken in the same cycle
      check_value("wready_o", 32'd1, wready);
    end
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!bvalid && t < HS_TIMEOUT);
    bready <= 1'b0;
    if (!bvalid) begin
      $display("Timeout: no write response for %h", addr);
      errors++;
    end else begin
      check_value("bresp_o", 32'd0, bresp);
    end
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    int unsigned t;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!arready && t < HS_TIMEOUT);
    arvalid <= 1'b0;
    if (!arready) begin
      $display("Timeout: read of %h was never accepted", addr);
      errors++;
    end
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!rvalid && t < HS_TIMEOUT);
    rready <= 1'b0;
    data = rdata;
    if (!rvalid) begin
      $display("Timeout: no read response for %h", addr);
      errors++;
    end else begin
      check_value("rresp_o", 32'd0, rresp);
    end
  endtask

  task automatic configure(input logic [31:0] src, dst, len, src_stride, dst_stride, reps);
    cfg_src        = src;
    cfg_dst        = dst;
    cfg_len        = len;
    cfg_src_stride = src_stride;
    cfg_dst_stride = dst_stride;
    cfg_reps       = reps;
    axi_write(`DMAC_REG_SRC, src);
    axi_write(`DMAC_REG_DST, dst);
    axi_write(`DMAC_REG_LEN, len);
    axi_write(`DMAC_REG_SRC_STRIDE, src_stride);
    axi_write(`DMAC_REG_DST_STRIDE, dst_stride);
    axi_write(`DMAC_REG_REPS, reps);
  endtask

  // NEXT_ID read, then the expected copy applied to the reference memory
  task automatic launch();
    logic [31:0] id;
    int unsigned s, d;
    axi_read(`DMAC_REG_NEXT_ID, id);
    launched++;
    check_value("rdata_o (NEXT_ID)", launched, id);
    for (int k = 0; k < cfg_reps; k++) begin
      for (int w = 0; w < cfg_len / 4; w++) begin
        s = (cfg_src + k * cfg_src_stride) / 4 + w;
        d = (cfg_dst + k * cfg_dst_stride) / 4 + w;
        ref_mem[d % MEM_WORDS] = ref_mem[s % MEM_WORDS];
      end
    end
  endtask

  task automatic wait_done();
    int unsigned t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while ((events != launched || busy) && t < XFER_TIMEOUT);
    if (events != launched || busy) begin
      $display("Timeout: transfers did not finish, %0d of %0d events", events, launched);
      errors++;
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("mem[%h]", i * 4), ref_mem[i], mem[i]);
    end
  endtask

  task automatic check_done_id();
    logic [31:0] got;
    axi_read(`DMAC_REG_DONE_ID, got);
    check_value("rdata_o (DONE_ID)", launched, got);
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_register_readback();
    logic [31:0] vals [6];
    logic [31:0] got;
    for (int i = 0; i < 6; i++) begin
      vals[i] = (i == 5) ? ($urandom & 32'hffff) : $urandom;
      axi_write(`DMAC_REG_SRC + 4 * i, vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      axi_read(`DMAC_REG_SRC + 4 * i, got);
      check_value($sformatf("rdata_o (reg %h)", 4 * i), vals[i], got);
    end
    check_done_id();
  endtask

  task automatic test_copy_1d();
    configure(32'h100, 32'h400, 32'd32, 32'h0, 32'h0, 32'd1);
    launch();
    wait_done();
    compare_memory();
    check_done_id();
  endtask

  task automatic test_copy_2d();
    configure(32'h200, 32'h800, 32'd16, 32'h40, 32'h30, 32'd4);
    launch();
    wait_done();
    compare_memory();
    check_done_id();
  endtask

  task automatic test_queued_launches();
    int unsigned first_event;
    first_event = events;
    configure(32'h000, 32'ha00, 32'd32, 32'h20, 32'h20, 32'd2);
    repeat (4) launch();
    wait_done();
    check_value("term_event_o pulses", 32'd4, events - first_event);
    compare_memory();
    check_done_id();
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    configure(32'h300, 32'hc00, 32'd24, 32'h20, 32'h40, 32'd3);
    launch();
    wait_done();
    stall_en = 1'b0;
    @(posedge clk);
    check_value("busy_o", 32'd0, busy);
    compare_memory();
    check_done_id();
  endtask

  initial begin
    void'($urandom(32'hfb07));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    errors = 0;
    checks = 0;
    events = 0;
    launched  = 0;
    stall_cnt = 0;
    rd_wait   = 0;
    rd_idx    = 0;
    stall_en  = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i * 4);
      ref_mem[i] = fill_word(i * 4);
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_register_readback();
    test_copy_1d();
    test_copy_2d();
    test_queued_launches();
    test_backpressure();
    repeat (5) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
